//--- src.f
verilog/periph_pkg.sv
verilog/bus_if.sv
verilog/bus_decoder.sv
verilog/timer_controller.sv
verilog/gpio_controller.sv
verilog/periph_top.sv
dv/tb_clock_gen.sv
dv/tb_periph_top.sv

//--- Bender.yml
package:
  name: periph

# RTL sources in compile order, the package first.
sources:
  - verilog/periph_pkg.sv
  - verilog/bus_if.sv
  - verilog/bus_decoder.sv
  - verilog/timer_controller.sv
  - verilog/gpio_controller.sv
  - verilog/periph_top.sv

  # Testbench, top module tb_periph_top.
  - target: test
    files:
      - dv/tb_clock_gen.sv
      - dv/tb_periph_top.sv

//--- dv/periph_stimulus.txt
# test op addr data expect, every field after the name in hex
# ops 0 wait, 1 timer wr, 2 timer rd (expect is tolerance), 3 gpio wr, 4 gpio rd,
#     5 gpio_in, 6 random gpio_in rd, 7 unmapped rd, 8 unmapped wr, 9 gpio_out
reset_gpio_out      9 00000000 00000000 00000000
reset_gpio_rd       4 00000104 00000000 00000000
reset_timer_rd      2 00000100 00000000 00000001
count_wait          0 00000000 00000037 00000000
count_timer_rd      2 00000100 00000000 00000001
count_wait_long     0 00000000 000000C8 00000000
count_timer_rd_long 2 00000100 00000000 00000001
timer_wr            1 00000100 00001234 00000000
timer_wr_rd         2 00000100 00000000 00000001
timer_wr_wait       0 00000000 0000002D 00000000
timer_wr_rd_later   2 00000100 00000000 00000001
timer_wr_wrap       1 00000100 FFFFFFF0 00000000
wrap_wait           0 00000000 000000B4 00000000
wrap_rd             2 00000100 00000000 00000001
gpio_wr             3 00000104 A5A5A53C 0000003C
gpio_wr_mask        3 00000104 FFFFFF81 00000081
gpio_in_drive       5 00000000 0000005A 00000000
gpio_in_rd          4 00000104 00000000 0000005A
gpio_in_random      6 00000104 00000000 00000000
unmapped_rd         7 00000108 00000000 00000000
unmapped_rd_near    7 00000101 00000000 00000000
unmapped_wr         8 00000200 000000FF 00000081
unmapped_wr_out     9 00000000 00000000 00000081
unmapped_timer_rd   2 00000100 00000000 00000001
gpio_wr_clear       3 00000104 00000000 00000000

//--- dv/tb_periph_top.sv
`timescale 1ns/100ps

module tb_periph_top;

    localparam int TIMER_PRESCALE = 10;
    localparam int GPIO_WIDTH = 8;
    localparam int HOLD_10M = 4;          // Timer write hold in clk_10M periods.
    localparam int SYNC_STAGES = 2;
    localparam int GPIO_HOLD = 3;         // Bus cycles that gpio_in is held before a read.
    localparam int RESET_TIMEOUT = 50;

    logic clk_10M;
    logic clk_bus;
    logic rst;
    periph_pkg::addr_t bus_addr;
    logic bus_read;
    logic bus_write;
    periph_pkg::word_t bus_data_wr;
    periph_pkg::word_t bus_data_rd;
    logic [GPIO_WIDTH-1:0] gpio_in;
    logic [GPIO_WIDTH-1:0] gpio_out;

    int cycles;                           // clk_10M rising edges since reset release.
    int load_cycle;                       // Cycle of the last timer load.
    periph_pkg::word_t timer_ref;         // Value loaded at load_cycle.
    integer seed;
    int ops_done;

    tb_clock_gen i_tb_clock_gen (
        .clk_10M (clk_10M),
        .clk_bus (clk_bus),
        .rst     (rst)
    );

    periph_top #(
        .TIMER_PRESCALE (TIMER_PRESCALE),
        .GPIO_WIDTH     (GPIO_WIDTH)
    ) i_periph_top (
        .clk_bus     (clk_bus),
        .clk_10M     (clk_10M),
        .rst         (rst),
        .bus_addr    (bus_addr),
        .bus_read    (bus_read),
        .bus_write   (bus_write),
        .bus_data_wr (bus_data_wr),
        .bus_data_rd (bus_data_rd),
        .gpio_in     (gpio_in),
        .gpio_out    (gpio_out)
    );

    always @(posedge clk_10M or posedge rst) begin
        if (rst) begin
            cycles <= 0;
        end else begin
            cycles <= cycles + 1;
        end
    end

    task automatic abort_run(input string reason);
        $display("ERROR: %s", reason);
        $display("Something failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input periph_pkg::word_t expected,
                               input periph_pkg::word_t actual);
        if (expected !== actual) begin
            $display("FAILED %s: expected 0x%08h, actual 0x%08h", name, expected, actual);
            $display("Something failed");
            $fatal(1);
        end
    endtask

    task automatic wait_bus_cycles(input int count);
        int done;
        done = 0;
        while (done < count) begin
            @(negedge clk_bus);
            done++;
        end
    endtask

    // Returns on a falling bus edge once the 10 MHz counter has moved on by count.
    task automatic wait_10m_cycles(input int count);
        int target;
        int guard;
        target = cycles + count;
        guard = 0;
        while (cycles < target) begin
            @(negedge clk_bus);
            guard++;
            if (guard > 3 * count + 8) begin
                abort_run("clk_10M stopped while waiting for timer cycles");
            end
        end
    endtask

    task automatic wait_reset_release();
        int guard;
        guard = 0;
        while (rst !== 1'b0) begin
            @(posedge clk_bus);
            guard++;
            if (guard > RESET_TIMEOUT) begin
                abort_run("reset was never released");
            end
        end
        wait_bus_cycles(1);
    endtask

    task automatic read_word(input periph_pkg::addr_t addr, output periph_pkg::word_t data,
                             output int at_cycle);
        bus_addr = addr;
        bus_read = 1'b1;
        wait_bus_cycles(1);
        data = bus_data_rd;
        at_cycle = cycles;
        bus_read = 1'b0;
    endtask

    task automatic write_word(input periph_pkg::addr_t addr, input periph_pkg::word_t data);
        bus_addr = addr;
        bus_data_wr = data;
        bus_write = 1'b1;
        wait_bus_cycles(1);
        bus_write = 1'b0;
    endtask

    // A write long enough for the 10 MHz side, then time for the load to settle.
    task automatic hold_write(input periph_pkg::addr_t addr, input periph_pkg::word_t data,
                              output int drop_cycle);
        bus_addr = addr;
        bus_data_wr = data;
        bus_write = 1'b1;
        wait_10m_cycles(HOLD_10M);
        bus_write = 1'b0;
        drop_cycle = cycles;
        wait_10m_cycles(SYNC_STAGES + 1);
    endtask

    task automatic check_timer(input string name, input periph_pkg::addr_t addr,
                               input periph_pkg::word_t tol);
        periph_pkg::word_t actual;
        periph_pkg::word_t expected;
        periph_pkg::word_t below;
        int at_cycle;
        read_word(addr, actual, at_cycle);
        expected = timer_ref + periph_pkg::word_t'((at_cycle - load_cycle) / TIMER_PRESCALE);
        below = expected - actual;
        if (below <= tol) begin
            expected = expected - below;    // The read may trail the live count.
        end
        check_value(name, expected, actual);
    endtask

    task automatic run_operation(input string name, input periph_pkg::word_t op,
                                 input periph_pkg::addr_t addr, input periph_pkg::word_t data,
                                 input periph_pkg::word_t expect_val);
        periph_pkg::word_t actual;
        periph_pkg::word_t pattern;
        int at_cycle;
        int drop_cycle;
        case (op)
            0: wait_10m_cycles(int'(data));
            1: begin
                hold_write(addr, data, drop_cycle);
                timer_ref = data;
                load_cycle = drop_cycle + SYNC_STAGES;
            end
            2: check_timer(name, addr, expect_val);
            3: begin
                write_word(addr, data);
                check_value(name, expect_val, periph_pkg::word_t'(gpio_out));
            end
            4, 7: begin
                read_word(addr, actual, at_cycle);
                check_value(name, expect_val, actual);
            end
            5: begin
                gpio_in = data[GPIO_WIDTH-1:0];
                wait_bus_cycles(GPIO_HOLD);
            end
            6: begin
                pattern = $random(seed);
                gpio_in = pattern[GPIO_WIDTH-1:0];
                wait_bus_cycles(GPIO_HOLD);
                read_word(addr, actual, at_cycle);
                check_value(name, periph_pkg::word_t'(pattern[GPIO_WIDTH-1:0]), actual);
            end
            8: begin
                hold_write(addr, data, drop_cycle);
                check_value(name, expect_val, periph_pkg::word_t'(gpio_out));
            end
            9: check_value(name, expect_val, periph_pkg::word_t'(gpio_out));
            default: abort_run("unknown operation code in the stimulus file");
        endcase
    endtask

    initial begin
        int fd;
        int fields;
        logic [8*160-1:0] line;
        logic [8*32-1:0] name_raw;
        logic [31:0] op_code;
        logic [31:0] addr_val;
        logic [31:0] data_val;
        logic [31:0] exp_val;
        bus_addr = '0;
        bus_read = 1'b0;
        bus_write = 1'b0;
        bus_data_wr = '0;
        gpio_in = '0;
        seed = 71585;
        timer_ref = '0;
        load_cycle = 0;
        ops_done = 0;
        wait_reset_release();
        fd = $fopen("dv/periph_stimulus.txt", "r");
        if (fd == 0) begin
            abort_run("cannot open dv/periph_stimulus.txt");
        end
        while ($fgets(line, fd) != 0) begin
            fields = $sscanf(line, "%s %h %h %h %h", name_raw, op_code, addr_val, data_val,
                             exp_val);
            if (fields == 5) begin    // Comment and blank lines do not parse.
                run_operation($sformatf("%0s", name_raw), op_code, addr_val, data_val, exp_val);
                ops_done++;
            end
        end
        $fclose(fd);
        if (ops_done == 0) begin
            abort_run("the stimulus file holds no operations");
        end else begin
            $display("Everything OK");
            $finish;
        end
    end

endmodule

//--- dv/tb_clock_gen.sv
`timescale 1ns/100ps

module tb_clock_gen (
    output logic clk_10M,
    output logic clk_bus,
    output logic rst
);

    initial begin
        clk_10M = 1'b0;
        forever #50 clk_10M = ~clk_10M;    // 100 ns period.
    end

    initial begin
        clk_bus = 1'b0;
        forever #20 clk_bus = ~clk_bus;    // 40 ns period.
    end

    // Reset spans three 10 MHz cycles and is released on a falling bus clock edge.
    initial begin
        rst = 1'b1;
        repeat (3) @(posedge clk_10M);
        @(negedge clk_bus);
        rst = 1'b0;
    end

endmodule

//--- verilog/periph_top.sv
`timescale 1ns/100ps

module periph_top #(
    parameter int TIMER_PRESCALE = 10000,    // 10 MHz down to 1 kHz.
    parameter int GPIO_WIDTH = 8
) (
    input logic clk_bus,
    input logic clk_10M,
    input logic rst,
    input periph_pkg::addr_t bus_addr,
    input logic bus_read,
    input logic bus_write,
    input periph_pkg::word_t bus_data_wr,
    output periph_pkg::word_t bus_data_rd,
    input logic [GPIO_WIDTH-1:0] gpio_in,
    output logic [GPIO_WIDTH-1:0] gpio_out
);

    bus_if timer_bus ();
    bus_if gpio_bus ();

    bus_decoder i_bus_decoder (
        .bus_addr    (bus_addr),
        .bus_read    (bus_read),
        .bus_write   (bus_write),
        .bus_data_wr (bus_data_wr),
        .bus_data_rd (bus_data_rd),
        .timer_bus   (timer_bus.master),
        .gpio_bus    (gpio_bus.master)
    );

    timer_controller #(
        .TIMER_PRESCALE (TIMER_PRESCALE)
    ) i_timer_controller (
        .clk_bus  (clk_bus),
        .clk_10M  (clk_10M),
        .rst      (rst),
        .data_bus (timer_bus.slave)
    );

    gpio_controller #(
        .GPIO_WIDTH (GPIO_WIDTH)
    ) i_gpio_controller (
        .clk_bus  (clk_bus),
        .rst      (rst),
        .data_bus (gpio_bus.slave),
        .gpio_in  (gpio_in),
        .gpio_out (gpio_out)
    );

endmodule

//--- verilog/gpio_controller.sv
`timescale 1ns/100ps

module gpio_controller #(
    parameter int GPIO_WIDTH = 8
) (
    input logic clk_bus,
    input logic rst,
    bus_if.slave data_bus,
    input logic [GPIO_WIDTH-1:0] gpio_in,
    output logic [GPIO_WIDTH-1:0] gpio_out
);

    logic [GPIO_WIDTH-1:0] in_meta;
    logic [GPIO_WIDTH-1:0] in_sync;
    periph_pkg::word_t in_word;

    // The output register drops the upper data bits.
    always_ff @(posedge clk_bus or posedge rst) begin
        if (rst) begin
            gpio_out <= '0;
        end else if (data_bus.write) begin
            gpio_out <= data_bus.data_wr[GPIO_WIDTH-1:0];
        end
    end

    // Pins are asynchronous to the bus clock.
    always_ff @(posedge clk_bus or posedge rst) begin
        if (rst) begin
            in_meta <= '0;
            in_sync <= '0;
        end else begin
            in_meta <= gpio_in;
            in_sync <= in_meta;
        end
    end

    assign in_word = periph_pkg::word_t'(in_sync);    // Zero-extended to a full word.

    assign data_bus.data_rd = data_bus.read ? in_word : periph_pkg::ZERO_WORD;

endmodule

//--- verilog/timer_controller.sv
`timescale 1ns/100ps

module timer_controller #(
    parameter int TIMER_PRESCALE = 10000
) (
    input logic clk_bus,
    input logic clk_10M,
    input logic rst,
    bus_if.slave data_bus
);

    localparam int PS_W = periph_pkg::PRESCALE_W;
    localparam logic [PS_W-1:0] PRESCALE_LAST = PS_W'(TIMER_PRESCALE - 1);

    periph_pkg::word_t timer;
    logic [PS_W-1:0] prescaler;
    logic tick;

    logic [1:0] write_sync;
    periph_pkg::word_t load_sync [0:1];
    logic load;

    periph_pkg::word_t timer_sync [0:1];

    // Bus write and data into the 10 MHz domain.
    always_ff @(posedge clk_10M or posedge rst) begin
        if (rst) begin
            write_sync <= 2'b00;
            load_sync[0] <= periph_pkg::ZERO_WORD;
            load_sync[1] <= periph_pkg::ZERO_WORD;
        end else begin
            write_sync <= {write_sync[0], data_bus.write};
            load_sync[0] <= data_bus.data_wr;
            load_sync[1] <= load_sync[0];    // Stable by the time write_sync[1] rises.
        end
    end

    assign load = write_sync[1];
    assign tick = (prescaler == PRESCALE_LAST);

    // A held write keeps reloading the millisecond counter and holds the prescaler.
    always_ff @(posedge clk_10M or posedge rst) begin
        if (rst) begin
            prescaler <= '0;
            timer <= periph_pkg::ZERO_WORD;
        end else if (load) begin
            prescaler <= '0;
            timer <= load_sync[1];
        end else if (tick) begin
            prescaler <= '0;
            timer <= timer + 1'b1;          // Wraps past all ones to zero.
        end else begin
            prescaler <= prescaler + 1'b1;
        end
    end

    // Count into the bus domain for reads.
    always_ff @(posedge clk_bus or posedge rst) begin
        if (rst) begin
            timer_sync[0] <= periph_pkg::ZERO_WORD;
            timer_sync[1] <= periph_pkg::ZERO_WORD;
        end else begin
            timer_sync[0] <= timer;
            timer_sync[1] <= timer_sync[0];
        end
    end

    assign data_bus.data_rd = data_bus.read ? timer_sync[1] : periph_pkg::ZERO_WORD;

endmodule

//--- verilog/bus_decoder.sv
`timescale 1ns/100ps

module bus_decoder (
    input periph_pkg::addr_t bus_addr,
    input logic bus_read,
    input logic bus_write,
    input periph_pkg::word_t bus_data_wr,
    output periph_pkg::word_t bus_data_rd,
    bus_if.master timer_bus,
    bus_if.master gpio_bus
);

    logic timer_sel;
    logic gpio_sel;

    // Addresses match whole words with no byte lanes or mirrors.
    assign timer_sel = (bus_addr == periph_pkg::TIMER_ADDR);
    assign gpio_sel = (bus_addr == periph_pkg::GPIO_ADDR);

    assign timer_bus.read = bus_read & timer_sel;
    assign timer_bus.write = bus_write & timer_sel;
    assign timer_bus.data_wr = bus_data_wr;     // Write data fans out to every slave.

    assign gpio_bus.read = bus_read & gpio_sel;
    assign gpio_bus.write = bus_write & gpio_sel;
    assign gpio_bus.data_wr = bus_data_wr;

    // Each slave returns zero unless it is read, so an OR merges the two words.
    // An address that selects no slave therefore reads back as zero.
    assign bus_data_rd = timer_bus.data_rd | gpio_bus.data_rd;

endmodule

//--- verilog/bus_if.sv
`timescale 1ns/100ps

interface bus_if;

    logic read;                    // A level qualified by the address decode.
    logic write;                   // A level qualified by the address decode.
    periph_pkg::word_t data_wr;
    periph_pkg::word_t data_rd;    // Zero while read is low.

    modport master (
        output read,
        output write,
        output data_wr,
        input data_rd
    );

    modport slave (
        input read,
        input write,
        input data_wr,
        output data_rd
    );

endinterface

//--- verilog/periph_pkg.sv
package periph_pkg;

    localparam int WORD_W = 32;
    localparam int ADDR_W = 32;

    // Wide enough for divide ratios up to 65536.
    localparam int PRESCALE_W = 16;

    typedef logic [WORD_W-1:0] word_t;
    typedef logic [ADDR_W-1:0] addr_t;

    localparam word_t ZERO_WORD = '0;

    // Each slave has one word in the register map.
    localparam addr_t TIMER_ADDR = 32'h0000_0100;
    localparam addr_t GPIO_ADDR = 32'h0000_0104;

endpackage
